// ==== Bender.yml ====
package:
  name: fetch_frontend

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/fetch_pkg.sv
      - rtl/fetch_pc_gen.sv
      - rtl/icache.sv
      - rtl/axi_read_master.sv
      - rtl/instr_buffer.sv
      - rtl/fetch_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_fetch_top.sv

// ==== rtl/axi_read_master.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module axi_read_master
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n_i,
    // Refill port from the icache
    input  logic        refill_req_i,
    input  fetch_addr_t refill_addr_i,
    output logic        refill_ready_o,
    output logic        refill_valid_o,
    output cache_line_t refill_data_o,
    // AR channel
    output axi_id_t     arid_o,
    output fetch_addr_t araddr_o,
    output logic [7:0]  arlen_o,
    output logic [2:0]  arsize_o,
    output logic [1:0]  arburst_o,
    output logic        arvalid_o,
    input  logic        arready_i,
    // R channel
    input  cache_line_t rdata_i,
    input  logic [1:0]  rresp_i,
    input  logic        rlast_i,
    input  logic        rvalid_i,
    output logic        rready_o
);

    axi_rd_state_e state_q;
    axi_rd_state_e state_d;
    fetch_addr_t   addr_q;
    logic          req_fire;
    logic          last_beat;

    assign req_fire  = refill_req_i && refill_ready_o;
    assign last_beat = (state_q == AR_DATA) && rvalid_i && rlast_i;

    // Single 16-byte INCR beat per refill
    assign arid_o    = axi_id_t'(`ICACHE_AXI_ID);
    assign araddr_o  = addr_q;
    assign arlen_o   = 8'd0;
    assign arsize_o  = 3'(LINE_OFF_W);
    assign arburst_o = 2'b01;

    assign refill_ready_o = (state_q == AR_IDLE);
    assign arvalid_o      = (state_q == AR_ADDR);
    assign rready_o       = (state_q == AR_DATA);

    // Beat goes straight back to the icache
    assign refill_valid_o = last_beat;
    assign refill_data_o  = rdata_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            AR_IDLE: if (req_fire)  state_d = AR_ADDR;
            AR_ADDR: if (arready_i) state_d = AR_DATA;
            AR_DATA: if (last_beat) state_d = AR_IDLE;
            default: state_d = AR_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= AR_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            addr_q <= refill_addr_i;
        end
    end

endmodule

// ==== rtl/fetch_cfg.svh ====
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// Datapath widths
`define FETCH_ADDR_W   32
`define FETCH_INSTR_W  32
`define FETCH_LINE_W   128

// Instructions per fetched line and per decode cycle
`define FETCH_WIDTH    4
`define DECODE_WIDTH   2

// Storage sizes
`define ICACHE_LINES   64
`define IBUF_DEPTH     8

`define RESET_PC       32'h1C00_0000

// AXI read channel
`define AXI_ID_W       4
`define ICACHE_AXI_ID  0

`endif

// ==== rtl/fetch_pc_gen.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_pc_gen
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n_i,
    input  redirect_t   redirect_i,
    input  logic        fetch_ready_i,
    output logic        fetch_valid_o,
    output fetch_addr_t fetch_req_o
);

    fetch_addr_t pc_q;
    fetch_addr_t next_line_pc;
    logic        valid_q;
    logic        fetch_fire;

    // Next request always starts on a line boundary
    assign next_line_pc = {pc_q[`FETCH_ADDR_W-1:LINE_OFF_W] + 1'b1, {LINE_OFF_W{1'b0}}};

    assign fetch_fire = valid_q && fetch_ready_i;

    assign fetch_valid_o = valid_q;
    assign fetch_req_o   = pc_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q    <= `RESET_PC;
            valid_q <= 1'b0;
        end else begin
            // Requests start one cycle out of reset
            valid_q <= 1'b1;
            if (redirect_i.valid) begin
                pc_q <= redirect_i.target;
            end else if (fetch_fire) begin
                pc_q <= next_line_pc;
            end
        end
    end

endmodule

// ==== rtl/fetch_pkg.sv ====
`include "fetch_cfg.svh"

package fetch_pkg;

    // Address split for a line-based cache
    localparam int BYTE_OFF_W = $clog2(`FETCH_INSTR_W / 8);
    localparam int WORD_OFF_W = $clog2(`FETCH_LINE_W / `FETCH_INSTR_W);
    localparam int LINE_OFF_W = BYTE_OFF_W + WORD_OFF_W;
    localparam int INDEX_W    = $clog2(`ICACHE_LINES);
    localparam int TAG_W      = `FETCH_ADDR_W - INDEX_W - LINE_OFF_W;

    typedef logic [`FETCH_ADDR_W-1:0]  fetch_addr_t;
    typedef logic [`FETCH_INSTR_W-1:0] instr_t;
    typedef instr_t [`FETCH_LINE_W/`FETCH_INSTR_W-1:0] cache_line_t;
    typedef logic [INDEX_W-1:0]        line_index_t;
    typedef logic [TAG_W-1:0]          line_tag_t;
    typedef logic [`AXI_ID_W-1:0]      axi_id_t;

    // One instruction as seen by decode
    typedef struct packed {
        logic        valid;
        fetch_addr_t pc;
        instr_t      instr;
    } fetch_packet_t;

    // Backend flush with its restart address
    typedef struct packed {
        logic        valid;
        fetch_addr_t target;
    } redirect_t;

    typedef enum logic [1:0] {IC_IDLE, IC_LOOKUP, IC_MISS, IC_REFILL} icache_state_e;
    typedef enum logic [1:0] {AR_IDLE, AR_ADDR, AR_DATA} axi_rd_state_e;

endpackage

// ==== rtl/fetch_top.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_top
    import fetch_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n_i,
    input  redirect_t                         redirect_i,
    // Decode side
    output fetch_packet_t [`DECODE_WIDTH-1:0] decode_o,
    input  logic [`DECODE_WIDTH-1:0]          accept_i,
    // AXI read address
    output axi_id_t                           arid_o,
    output fetch_addr_t                       araddr_o,
    output logic [7:0]                        arlen_o,
    output logic [2:0]                        arsize_o,
    output logic [1:0]                        arburst_o,
    output logic                              arvalid_o,
    input  logic                              arready_i,
    // AXI read data
    input  cache_line_t                       rdata_i,
    input  logic [1:0]                        rresp_i,
    input  logic                              rlast_i,
    input  logic                              rvalid_i,
    output logic                              rready_o
);

    // PC generator to icache
    logic        fetch_valid;
    logic        fetch_ready;
    fetch_addr_t fetch_req;

    // Icache to buffer
    logic        space_ok;
    logic        line_valid;
    cache_line_t line;
    fetch_addr_t line_pc;

    // Icache to AXI master
    logic        refill_req;
    fetch_addr_t refill_addr;
    logic        refill_ready;
    logic        refill_valid;
    cache_line_t refill_data;

    fetch_pc_gen u_fetch_pc_gen (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .redirect_i    (redirect_i),
        .fetch_ready_i (fetch_ready),
        .fetch_valid_o (fetch_valid),
        .fetch_req_o   (fetch_req)
    );

    icache u_icache (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .redirect_i     (redirect_i),
        .fetch_valid_i  (fetch_valid),
        .fetch_req_i    (fetch_req),
        .fetch_ready_o  (fetch_ready),
        .space_ok_i     (space_ok),
        .line_valid_o   (line_valid),
        .line_o         (line),
        .line_pc_o      (line_pc),
        .refill_req_o   (refill_req),
        .refill_addr_o  (refill_addr),
        .refill_ready_i (refill_ready),
        .refill_valid_i (refill_valid),
        .refill_data_i  (refill_data)
    );

    axi_read_master u_axi_read_master (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .refill_req_i   (refill_req),
        .refill_addr_i  (refill_addr),
        .refill_ready_o (refill_ready),
        .refill_valid_o (refill_valid),
        .refill_data_o  (refill_data),
        .arid_o         (arid_o),
        .araddr_o       (araddr_o),
        .arlen_o        (arlen_o),
        .arsize_o       (arsize_o),
        .arburst_o      (arburst_o),
        .arvalid_o      (arvalid_o),
        .arready_i      (arready_i),
        .rdata_i        (rdata_i),
        .rresp_i        (rresp_i),
        .rlast_i        (rlast_i),
        .rvalid_i       (rvalid_i),
        .rready_o       (rready_o)
    );

    instr_buffer u_instr_buffer (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .redirect_i   (redirect_i),
        .line_valid_i (line_valid),
        .line_i       (line),
        .line_pc_i    (line_pc),
        .space_ok_o   (space_ok),
        .accept_i     (accept_i),
        .decode_o     (decode_o)
    );

endmodule

// ==== rtl/icache.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module icache
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n_i,
    input  redirect_t   redirect_i,
    // Request from the PC generator
    input  logic        fetch_valid_i,
    input  fetch_addr_t fetch_req_i,
    output logic        fetch_ready_o,
    // Line to the instruction buffer
    input  logic        space_ok_i,
    output logic        line_valid_o,
    output cache_line_t line_o,
    output fetch_addr_t line_pc_o,
    // Refill port to the AXI master
    output logic        refill_req_o,
    output fetch_addr_t refill_addr_o,
    input  logic        refill_ready_i,
    input  logic        refill_valid_i,
    input  cache_line_t refill_data_i
);

    icache_state_e state_q;
    icache_state_e state_d;

    fetch_addr_t req_q;
    logic        drop_q;

    logic [`ICACHE_LINES-1:0] valid_q;
    line_tag_t                tag_mem  [`ICACHE_LINES];
    cache_line_t              data_mem [`ICACHE_LINES];

    line_index_t req_idx;
    line_tag_t   req_tag;
    logic        hit;
    logic        fetch_fire;
    logic        refill_done;

    assign req_idx = req_q[LINE_OFF_W +: INDEX_W];
    assign req_tag = req_q[LINE_OFF_W + INDEX_W +: TAG_W];
    assign hit     = valid_q[req_idx] && (tag_mem[req_idx] == req_tag);

    // Only one line in flight, so space seen in IDLE already counts it
    assign fetch_ready_o = (state_q == IC_IDLE) && space_ok_i && !redirect_i.valid;
    assign fetch_fire    = fetch_valid_i && fetch_ready_o;
    assign refill_done   = (state_q == IC_REFILL) && refill_valid_i;

    assign line_valid_o = (state_q == IC_LOOKUP) && hit && !redirect_i.valid;
    assign line_o       = data_mem[req_idx];
    assign line_pc_o    = req_q;

    assign refill_req_o  = (state_q == IC_MISS);
    assign refill_addr_o = {req_q[`FETCH_ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};

    always_comb begin
        state_d = state_q;
        case (state_q)
            IC_IDLE: begin
                if (fetch_fire) begin
                    state_d = IC_LOOKUP;
                end
            end
            IC_LOOKUP: begin
                if (redirect_i.valid || hit) begin
                    state_d = IC_IDLE;
                end else begin
                    state_d = IC_MISS;
                end
            end
            IC_MISS: begin
                if (refill_ready_i) begin
                    state_d = IC_REFILL;
                end
            end
            IC_REFILL: begin
                // Filled line is replayed through LOOKUP unless flushed
                if (refill_valid_i) begin
                    state_d = (drop_q || redirect_i.valid) ? IC_IDLE : IC_LOOKUP;
                end
            end
            default: state_d = IC_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IC_IDLE;
            drop_q  <= 1'b0;
            valid_q <= '0;
        end else begin
            state_q <= state_d;
            if (fetch_fire) begin
                drop_q <= 1'b0;
            end else if (redirect_i.valid &&
                         (state_q == IC_MISS || state_q == IC_REFILL)) begin
                drop_q <= 1'b1;
            end
            if (refill_done) begin
                valid_q[req_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_fire) begin
            req_q <= fetch_req_i;
        end
        // Refill always lands, even for a flushed request
        if (refill_done) begin
            tag_mem[req_idx]  <= req_tag;
            data_mem[req_idx] <= refill_data_i;
        end
    end

endmodule

// ==== rtl/instr_buffer.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module instr_buffer
    import fetch_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  redirect_t                           redirect_i,
    // Line from the icache
    input  logic                                line_valid_i,
    input  cache_line_t                         line_i,
    input  fetch_addr_t                         line_pc_i,
    output logic                                space_ok_o,
    // Decode side
    input  logic [`DECODE_WIDTH-1:0]            accept_i,
    output fetch_packet_t [`DECODE_WIDTH-1:0]   decode_o
);

    localparam int PTR_W = $clog2(`IBUF_DEPTH);
    localparam int POP_W = $clog2(`DECODE_WIDTH) + 1;

    fetch_addr_t pc_mem    [`IBUF_DEPTH];
    instr_t      instr_mem [`IBUF_DEPTH];

    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W:0]   count_q;

    logic                     wr_en;
    logic [WORD_OFF_W-1:0]    first_word;
    logic [WORD_OFF_W:0]      n_wr;
    logic [`DECODE_WIDTH-1:0] pop_chain;
    logic [POP_W-1:0]         n_pop;

    // Words before the PC offset are not part of the stream
    assign wr_en      = line_valid_i && !redirect_i.valid;
    assign first_word = line_pc_i[LINE_OFF_W-1:BYTE_OFF_W];
    assign n_wr       = wr_en ? ((WORD_OFF_W + 1)'(`FETCH_WIDTH) - first_word) : '0;

    assign space_ok_o = (count_q <= (PTR_W + 1)'(`IBUF_DEPTH - `FETCH_WIDTH));

    // Two oldest entries straight from the head
    always_comb begin
        for (int k = 0; k < `DECODE_WIDTH; k++) begin
            decode_o[k].valid = (count_q > k);
            decode_o[k].pc    = pc_mem[rd_ptr_q + PTR_W'(k)];
            decode_o[k].instr = instr_mem[rd_ptr_q + PTR_W'(k)];
        end
    end

    // A slot only leaves when every older slot leaves with it
    always_comb begin
        n_pop = '0;
        for (int k = 0; k < `DECODE_WIDTH; k++) begin
            pop_chain[k] = accept_i[k] && decode_o[k].valid;
            if (k > 0) begin
                pop_chain[k] = pop_chain[k] && pop_chain[k-1];
            end
            n_pop = n_pop + POP_W'(pop_chain[k]);
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (redirect_i.valid) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            rd_ptr_q <= rd_ptr_q + PTR_W'(n_pop);
            wr_ptr_q <= wr_ptr_q + PTR_W'(n_wr);
            count_q  <= count_q + (PTR_W + 1)'(n_wr) - (PTR_W + 1)'(n_pop);
        end
    end

    // Each word keeps its own address
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                if (i >= first_word) begin
                    instr_mem[wr_ptr_q + PTR_W'(i - int'(first_word))] <= line_i[i];
                    pc_mem[wr_ptr_q + PTR_W'(i - int'(first_word))] <=
                        {line_pc_i[`FETCH_ADDR_W-1:LINE_OFF_W], WORD_OFF_W'(i),
                         {BYTE_OFF_W{1'b0}}};
                end
            end
        end
    end

endmodule

// ==== sources.f ====
+incdir+rtl
rtl/fetch_pkg.sv
rtl/fetch_pc_gen.sv
rtl/icache.sv
rtl/axi_read_master.sv
rtl/instr_buffer.sv
rtl/fetch_top.sv
verif/tb_clk_gen.sv
verif/tb_fetch_top.sv

// ==== verif/fetch_cases.txt ====
# redir target count accept_pct dly_min dly_max
# redir 0 starts at the reset PC, target in hex, other columns decimal
0 1C000000 32 100 0 3
1 1C000104 30 60 1 5
1 1C000008 20 30 0 2
1 1C010100 8 80 0 3
1 1C000100 8 80 0 3
1 1C010100 8 80 0 3
1 1C000A0C 17 100 20 40
1 1C000300 12 50 15 30
1 1C000014 24 25 0 4
1 1C000384 28 75 2 8

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // 20 ns period
    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    // Reset held for 10 cycles and released on a falling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (10) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

// ==== verif/tb_fetch_top.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module tb_fetch_top
    import fetch_pkg::*;
();

    localparam int          MAX_CASES = 32;
    localparam logic [31:0] RAND_SEED = 32'h4490_5282;
    localparam instr_t      MEM_KEY   = 32'hA5A5_5A5A;

    logic clk;
    logic rst_n_i;

    redirect_t                         redirect_i;
    fetch_packet_t [`DECODE_WIDTH-1:0] decode_o;
    logic [`DECODE_WIDTH-1:0]          accept_i;
    axi_id_t                           arid_o;
    fetch_addr_t                       araddr_o;
    logic [7:0]                        arlen_o;
    logic [2:0]                        arsize_o;
    logic [1:0]                        arburst_o;
    logic                              arvalid_o;
    logic                              arready_i;
    cache_line_t                       rdata_i;
    logic [1:0]                        rresp_i;
    logic                              rlast_i;
    logic                              rvalid_i;
    logic                              rready_o;

    // Case table from the data file
    int          case_redir  [MAX_CASES];
    fetch_addr_t case_target [MAX_CASES];
    int          case_count  [MAX_CASES];
    int          case_pct    [MAX_CASES];
    int          case_dmin   [MAX_CASES];
    int          case_dmax   [MAX_CASES];
    int          num_cases;

    // AXI memory model state
    int          dly_min;
    int          dly_max;
    fetch_addr_t ar_log [$];
    int          ar_total;

    // Lines the cache should hold after each test stream
    logic      ref_valid [`ICACHE_LINES];
    line_tag_t ref_tag   [`ICACHE_LINES];

    int error_count;
    int checks_done;
    int cycle_count = 0;
    int cycle_limit = 0;

    tb_clk_gen u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n_i)
    );

    fetch_top UUT (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .redirect_i (redirect_i),
        .decode_o   (decode_o),
        .accept_i   (accept_i),
        .arid_o     (arid_o),
        .araddr_o   (araddr_o),
        .arlen_o    (arlen_o),
        .arsize_o   (arsize_o),
        .arburst_o  (arburst_o),
        .arvalid_o  (arvalid_o),
        .arready_i  (arready_i),
        .rdata_i    (rdata_i),
        .rresp_i    (rresp_i),
        .rlast_i    (rlast_i),
        .rvalid_i   (rvalid_i),
        .rready_o   (rready_o)
    );

    task automatic check_addr(string name, fetch_addr_t got, fetch_addr_t exp);
        checks_done++;
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_instr(string name, instr_t got, instr_t exp);
        checks_done++;
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        checks_done++;
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        checks_done++;
        if (got !== exp) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    // Every memory word holds its own address scrambled
    function automatic instr_t mem_word(fetch_addr_t addr);
        return addr ^ MEM_KEY;
    endfunction

    function automatic cache_line_t mem_line(fetch_addr_t addr);
        cache_line_t line;
        for (int k = 0; k < `FETCH_WIDTH; k++) begin
            line[k] = mem_word(addr + fetch_addr_t'(4 * k));
        end
        return line;
    endfunction

    function automatic fetch_addr_t line_base(fetch_addr_t addr);
        return addr & ~fetch_addr_t'((`FETCH_LINE_W / 8) - 1);
    endfunction

    // Walk the lines of a stream through a direct-mapped model
    function automatic int expected_misses(fetch_addr_t first, fetch_addr_t last);
        fetch_addr_t a;
        line_index_t idx;
        line_tag_t   tag;
        int          misses;
        misses = 0;
        a = first;
        while (a <= last) begin
            idx = a[LINE_OFF_W +: INDEX_W];
            tag = a[LINE_OFF_W + INDEX_W +: TAG_W];
            if (!(ref_valid[idx] && ref_tag[idx] == tag)) begin
                misses++;
                ref_valid[idx] = 1'b1;
                ref_tag[idx]   = tag;
            end
            a = a + fetch_addr_t'(`FETCH_LINE_W / 8);
        end
        return misses;
    endfunction

    // Prefetch past the stream end lands outside this window
    function automatic int count_ar_in_range(fetch_addr_t first, fetch_addr_t last);
        int hits;
        hits = 0;
        foreach (ar_log[i]) begin
            if (ar_log[i] >= first && ar_log[i] <= last) hits++;
        end
        return hits;
    endfunction

    task automatic read_cases(output bit ok);
        int          fd;
        int          n;
        string       text;
        int          redir;
        fetch_addr_t target;
        int          cnt;
        int          pct;
        int          dmin;
        int          dmax;
        ok = 1'b0;
        num_cases = 0;
        fd = $fopen("verif/fetch_cases.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && num_cases < MAX_CASES) begin
                n = $fgets(text, fd);
                if (n > 0 && text[0] != "#") begin
                    if ($sscanf(text, "%d %h %d %d %d %d",
                                redir, target, cnt, pct, dmin, dmax) == 6) begin
                        case_redir[num_cases]  = redir;
                        case_target[num_cases] = target;
                        case_count[num_cases]  = cnt;
                        case_pct[num_cases]    = pct;
                        case_dmin[num_cases]   = dmin;
                        case_dmax[num_cases]   = dmax;
                        num_cases++;
                    end
                end
            end
            $fclose(fd);
            ok = (num_cases > 0);
        end
    endtask

    // One AR and one R beat per call with delays from the current case
    task automatic serve_read();
        fetch_addr_t addr;
        int          gap;
        @(negedge clk);
        if (rst_n_i && arvalid_o) begin
            addr = araddr_o;
            check_addr("araddr_o", addr, line_base(addr));
            check_count("arid_o", int'(arid_o), `ICACHE_AXI_ID);
            check_count("arlen_o", int'(arlen_o), 0);
            check_count("arsize_o", int'(arsize_o), 4);
            check_count("arburst_o", int'(arburst_o), 1);
            gap = $urandom_range(dly_max, dly_min);
            repeat (gap) @(negedge clk);
            arready_i = 1'b1;
            @(negedge clk);
            arready_i = 1'b0;
            ar_log.push_back(addr);
            ar_total++;
            gap = $urandom_range(dly_max, dly_min);
            repeat (gap) @(negedge clk);
            rdata_i  = mem_line(addr);
            rlast_i  = 1'b1;
            rvalid_i = 1'b1;
            @(negedge clk);
            rvalid_i = 1'b0;
            rlast_i  = 1'b0;
        end
    endtask

    task automatic apply_redirect(fetch_addr_t target);
        @(negedge clk);
        accept_i          = '0;
        redirect_i.valid  = 1'b1;
        redirect_i.target = target;
        @(negedge clk);
        redirect_i = '0;
        // Buffer must be flushed one cycle later
        check_flag("decode_o[0].valid", decode_o[0].valid, 1'b0);
        check_flag("decode_o[1].valid", decode_o[1].valid, 1'b0);
    endtask

    task automatic run_case(int c);
        fetch_addr_t              start;
        fetch_addr_t              exp_pc;
        int                       remaining;
        int                       errors_before;
        int                       exp_ar;
        int                       got_ar;
        logic                     taken;
        logic [`DECODE_WIDTH-1:0] acc;
        errors_before = error_count;
        dly_min = case_dmin[c];
        dly_max = case_dmax[c];
        start = (case_redir[c] != 0) ? case_target[c] : `RESET_PC;
        ar_log.delete();
        if (case_redir[c] != 0) apply_redirect(start);
        exp_pc = start;
        remaining = case_count[c];
        while (remaining > 0) begin
            @(negedge clk);
            acc = '0;
            if ($urandom_range(99) < case_pct[c]) acc[0] = 1'b1;
            // Slot 1 offered alone must stay put
            if (remaining > 1 && $urandom_range(99) < case_pct[c]) acc[1] = 1'b1;
            accept_i = acc;
            taken = 1'b1;
            for (int k = 0; k < `DECODE_WIDTH; k++) begin
                taken = taken && acc[k] && decode_o[k].valid;
                if (taken) begin
                    check_addr($sformatf("decode_o[%0d].pc", k), decode_o[k].pc, exp_pc);
                    check_instr($sformatf("decode_o[%0d].instr", k), decode_o[k].instr,
                                mem_word(exp_pc));
                    exp_pc = exp_pc + 4;
                    remaining--;
                end
            end
        end
        @(negedge clk);
        accept_i = '0;
        exp_ar = expected_misses(line_base(start), line_base(exp_pc - 4));
        got_ar = count_ar_in_range(line_base(start), line_base(exp_pc - 4));
        check_count("ar handshakes", got_ar, exp_ar);
        $display("case %0d at %h: %0d instructions, %0d AR expected %0d, %0d errors",
                 c + 1, start, case_count[c], got_ar, exp_ar, error_count - errors_before);
    endtask

    initial begin
        forever serve_read();
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout: tests did not finish within %0d cycles", cycle_limit);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        bit cases_ok;
        redirect_i  = '0;
        accept_i    = '0;
        arready_i   = 1'b0;
        rdata_i     = '0;
        rresp_i     = 2'b00;
        rlast_i     = 1'b0;
        rvalid_i    = 1'b0;
        dly_min     = 0;
        dly_max     = 0;
        ar_total    = 0;
        error_count = 0;
        checks_done = 0;
        for (int i = 0; i < `ICACHE_LINES; i++) begin
            ref_valid[i] = 1'b0;
            ref_tag[i]   = '0;
        end
        void'($urandom(RAND_SEED));
        read_cases(cases_ok);
        if (!cases_ok) begin
            $display("Could not read any test case from verif/fetch_cases.txt");
            $display("TB FAILED");
            $finish;
        end else begin
            // Budget per instruction scales with accept rate and AXI delay
            cycle_limit = 1000;
            for (int c = 0; c < num_cases; c++) begin
                cycle_limit += case_count[c] * ((100 + case_pct[c] - 1) / case_pct[c]) *
                               (case_dmax[c] + 8);
            end
            @(posedge rst_n_i);
            @(negedge clk);
            check_flag("decode_o[0].valid", decode_o[0].valid, 1'b0);
            check_flag("decode_o[1].valid", decode_o[1].valid, 1'b0);
            check_flag("arvalid_o", arvalid_o, 1'b0);
            check_flag("rready_o", rready_o, 1'b0);
            for (int c = 0; c < num_cases; c++) begin
                run_case(c);
            end
            $display("%0d cases, %0d checks, %0d errors, %0d AR handshakes in total",
                     num_cases, checks_done, error_count, ar_total);
            if (error_count == 0) begin
                $display("TB PASSED");
            end else begin
                $display("TB FAILED");
            end
            $finish;
        end
    end

endmodule
